// File: Bender.yml
package:
  name: tiled_mem

sources:
  # design, package first
  - files:
      - hw/tiled_mem_pkg.sv
      - hw/mem_tile.sv
      - hw/access_ctrl.sv
      - hw/tile_bank.sv
      - hw/tiled_mem_top.sv

  # verification
  - target: test
    files:
      - verif/tiled_mem_props.sv
      - verif/tb_tiled_mem.sv

// File: hw/access_ctrl.sv
`timescale 1ns/1ps

// address decode and read tracking
// enables are combinational from req, select and rd_valid one cycle later
module access_ctrl import tiled_mem_pkg::*; #(
    parameter int unsigned N_TILES = 4,     // power of two, 1 to 16
    localparam int unsigned TILE_W = (N_TILES > 1) ? $clog2(N_TILES) : 1,
    localparam int unsigned ROW_W  = ADDR_W - $clog2(N_TILES)
) (
    input  logic                clk,
    input  logic                reset,
    input  mem_req_t            req,            // packed access from top
    output logic [N_TILES-1:0]  tile_w_en,      // one-hot or zero
    output logic [N_TILES-1:0]  tile_r_en,      // one-hot or zero
    output logic [ROW_W-1:0]    row,            // row inside the tile
    output word_t               wdata,          // write word, passed on
    output logic [TILE_W-1:0]   tile_sel_q,     // tile of the last read
    output logic                rd_valid        // one pulse per read
);

    logic [TILE_W-1:0]  tile_idx;   // high address bits
    logic [N_TILES-1:0] tile_hit;   // decoded tile, before strobes
    ctrl_state_t        state;
    ctrl_state_t        state_next;

    // tile index is whatever sits above the row bits
    // shift form keeps the single tile case at index zero
    assign tile_idx = TILE_W'(req.addr >> ROW_W);
    assign row      = req.addr[ROW_W-1:0];
    assign wdata    = req.wdata;

    // one-hot decoder
    always_comb begin
        tile_hit           = '0;
        tile_hit[tile_idx] = 1'b1;
    end

    // strobes gate the decode, no access means all zero
    assign tile_w_en = tile_hit & {N_TILES{req.w_en}};
    assign tile_r_en = tile_hit & {N_TILES{req.r_en}};

    // read tracking fsm
    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (req.r_en) state_next = read_pending;
            end
            read_pending: begin
                // back to back read stays here, new select below
                if (!req.r_en) state_next = idle;
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= idle;
            tile_sel_q <= '0;
        end else begin
            state <= state_next;
            if (req.r_en) begin
                tile_sel_q <= tile_idx;     // tracks the tile that registers data now
            end
        end
    end

    // valid while the tile output belongs to last cycle's read
    assign rd_valid = (state == read_pending);

endmodule

// File: hw/mem_tile.sv
`timescale 1ns/1ps

// one block-ram sized tile
// separate write and read ports, read is registered
module mem_tile import tiled_mem_pkg::*; #(
    parameter int unsigned ROW_W = 10       // rows per tile is 2**ROW_W
) (
    input  logic             clk,
    input  logic             w_en,          // write strobe, already tile gated
    input  logic             r_en,          // read strobe, already tile gated
    input  logic [ROW_W-1:0] w_addr,        // write row
    input  logic [ROW_W-1:0] r_addr,        // read row
    input  word_t            data_in,       // write word
    output word_t            data_out       // registered read word
);

    localparam int unsigned N_ROWS = 2 ** ROW_W;

    // storage array, maps onto one bram
    word_t mem [N_ROWS];

    // write port
    always_ff @(posedge clk) begin
        if (w_en) begin
            mem[w_addr] <= data_in;
        end
    end

    // read port
    // nonblocking read samples the array before this edge's write lands,
    // so a same row read and write returns the old word
    always_ff @(posedge clk) begin
        if (r_en) begin
            data_out <= mem[r_addr];    // holds when r_en is low
        end
    end

endmodule

// File: hw/tile_bank.sv
`timescale 1ns/1ps

// array of tiles plus the output mux
// row and write word fan out to all tiles, enables pick one
module tile_bank import tiled_mem_pkg::*; #(
    parameter int unsigned N_TILES = 4,     // power of two, 1 to 16
    localparam int unsigned TILE_W = (N_TILES > 1) ? $clog2(N_TILES) : 1,
    localparam int unsigned ROW_W  = ADDR_W - $clog2(N_TILES)
) (
    input  logic                clk,
    input  logic [N_TILES-1:0]  tile_w_en,      // one-hot write enable
    input  logic [N_TILES-1:0]  tile_r_en,      // one-hot read enable
    input  logic [ROW_W-1:0]    row,            // shared row address
    input  word_t               wdata,          // shared write word
    input  logic [TILE_W-1:0]   tile_sel_q,     // registered tile index
    output word_t               data_out        // selected tile word
);

    // registered outputs of every tile
    word_t tile_dout [N_TILES];

    for (genvar i = 0; i < N_TILES; i++) begin : g_tile
        mem_tile #(
            .ROW_W    (ROW_W)
        ) u_tile (
            .clk      (clk),
            .w_en     (tile_w_en[i]),
            .r_en     (tile_r_en[i]),
            .w_addr   (row),            // single address port, both sides same row
            .r_addr   (row),
            .data_in  (wdata),
            .data_out (tile_dout[i])
        );
    end

    // output mux
    // the select was registered on the same edge as the tile read,
    // so it always names the tile holding the current word
    // with no read both select and tile hold, so data_out holds too
    assign data_out = tile_dout[tile_sel_q];

endmodule

// File: hw/tiled_mem_pkg.sv
package tiled_mem_pkg;

    // memory geometry, 4096 words of 32 bits
    localparam int unsigned DATA_W = 32;    // word width
    localparam int unsigned ADDR_W = 12;    // full word address

    // memory word as seen on every data path
    typedef logic [DATA_W-1:0] word_t;

    // full word address, tile bits on top and row bits below
    typedef logic [ADDR_W-1:0] addr_t;

    // one access as it enters the control block
    // w_en and r_en may both be set in the same cycle
    typedef struct packed {
        logic  w_en;    // write strobe
        logic  r_en;    // read strobe
        addr_t addr;    // shared address for both strobes
        word_t wdata;   // write word, ignored on reads
    } mem_req_t;        // 46 bits total

    // read tracking in access_ctrl
    // read_pending is the cycle in which the tile output is valid
    typedef enum logic [0:0] {
        idle         = 1'b0,    // no read in flight
        read_pending = 1'b1     // read issued last cycle
    } ctrl_state_t;

endpackage

// File: hw/tiled_mem_top.sv
`timescale 1ns/1ps

// tiled 4096 x 32 memory, one access per cycle
// read data and rd_valid appear one clock after r_en
module tiled_mem_top import tiled_mem_pkg::*; #(
    parameter int unsigned N_TILES = 4,     // power of two, 1 to 16
    localparam int unsigned TILE_W = (N_TILES > 1) ? $clog2(N_TILES) : 1,
    localparam int unsigned ROW_W  = ADDR_W - $clog2(N_TILES)
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  w_en,         // write strobe
    input  logic  r_en,         // read strobe
    input  addr_t addr,         // word address for both strobes
    input  word_t data_in,      // write word
    output word_t data_out,     // read word, holds between reads
    output logic  rd_valid      // one cycle pulse per read
);

    mem_req_t           req;            // bundled access
    logic [N_TILES-1:0] tile_w_en;
    logic [N_TILES-1:0] tile_r_en;
    logic [ROW_W-1:0]   row;
    word_t              wdata;
    logic [TILE_W-1:0]  tile_sel_q;

    // pack the pins into one request
    assign req = '{w_en: w_en, r_en: r_en, addr: addr, wdata: data_in};

    access_ctrl #(
        .N_TILES    (N_TILES)
    ) u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .tile_w_en  (tile_w_en),
        .tile_r_en  (tile_r_en),
        .row        (row),
        .wdata      (wdata),
        .tile_sel_q (tile_sel_q),
        .rd_valid   (rd_valid)
    );

    tile_bank #(
        .N_TILES    (N_TILES)
    ) u_bank (
        .clk        (clk),
        .tile_w_en  (tile_w_en),
        .tile_r_en  (tile_r_en),
        .row        (row),
        .wdata      (wdata),
        .tile_sel_q (tile_sel_q),   // no reset path into the bank
        .data_out   (data_out)
    );

endmodule

// File: project.f
hw/tiled_mem_pkg.sv
hw/mem_tile.sv
hw/access_ctrl.sv
hw/tile_bank.sv
hw/tiled_mem_top.sv
verif/tiled_mem_props.sv
verif/tb_tiled_mem.sv

// File: verif/tb_tiled_mem.sv
`timescale 1ns/1ps

// testbench for the tiled memory
// every op and every expected read word comes from the golden file
module tb_tiled_mem import tiled_mem_pkg::*; ();

    localparam int N_TILES      = 4;
    localparam int CLK_HALF     = 10;       // 20 ns period
    localparam int RESET_CYCLES = 8;
    localparam int MAX_OPS      = 128;      // room in the golden array

    logic  clk;
    logic  reset;
    logic  w_en;
    logic  r_en;
    addr_t addr;
    word_t data_in;
    word_t data_out;
    logic  rd_valid;

    // four columns per op, op / addr / wdata / expected
    logic [31:0] golden [0:4*MAX_OPS-1];

    int          n_ops;
    int          op_idx;
    int          idle_n;
    int          limit;
    bit          limit_ready = 1'b0;
    int          cycle_count;
    int          test_no;
    int          test_checks;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    int          load_errors;
    int          assert_fails;
    word_t       last_word;                 // what data_out must hold between reads
    bit          have_read;                 // data_out unknown until the first read

    tiled_mem_top #(
        .N_TILES  (N_TILES)
    ) dut0 (
        .clk      (clk),
        .reset    (reset),
        .w_en     (w_en),
        .r_en     (r_en),
        .addr     (addr),
        .data_in  (data_in),
        .data_out (data_out),
        .rd_valid (rd_valid)
    );

    always #(CLK_HALF) clk = ~clk;

    // read word against the golden value
    task automatic check_word(input word_t actual, input word_t expected, input int idx);
        test_checks++;
        if (actual !== expected) begin
            $display("Error at %0t ns: data_out %h, expected %h, golden op %0d",
                     $time, actual, expected, idx);
            test_errors++;
        end
    endtask

    // read-valid pulse against the expected level
    task automatic check_valid(input logic actual, input logic expected, input int idx);
        test_checks++;
        if (actual !== expected) begin
            $display("Error at %0t ns: rd_valid %b, expected %b, golden op %0d",
                     $time, actual, expected, idx);
            test_errors++;
        end
    endtask

    // one cycle with no strobe, outputs must hold and stay not valid
    task automatic idle_cycle(input int idx);
        @(posedge clk);
        @(negedge clk);
        check_valid(rd_valid, 1'b0, idx);
        if (have_read) begin
            check_word(data_out, last_word, idx);
        end
    endtask

    // drive one golden op, check its result one edge later
    task automatic run_op(input int idx);
        logic [31:0] op;
        word_t       expected;
        op       = golden[4*idx];
        expected = golden[4*idx+3];
        w_en     = op[0];                   // kind bit 0 is write
        r_en     = op[1];                   // kind bit 1 is read
        addr     = addr_t'(golden[4*idx+1]);
        data_in  = golden[4*idx+2];
        @(posedge clk);                     // strobes sampled here
        @(negedge clk);
        w_en    = 1'b0;
        r_en    = 1'b0;
        addr    = '0;
        data_in = '0;
        if (op[1]) begin
            check_valid(rd_valid, 1'b1, idx);
            check_word(data_out, expected, idx);
            last_word = expected;
            have_read = 1'b1;
        end else begin
            check_valid(rd_valid, 1'b0, idx);   // writes and idles never pulse
            if (have_read) begin
                check_word(data_out, last_word, idx);
            end
        end
    endtask

    // per test summary line
    task automatic finish_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d done: %0d checks, all matched", test_no, test_checks);
        end else begin
            tests_failed++;
            $display("test %0d done: %0d checks, %0d mismatches",
                     test_no, test_checks, test_errors);
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        w_en         = 1'b0;
        r_en         = 1'b0;
        addr         = '0;
        data_in      = '0;
        test_no      = 0;
        test_checks  = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        load_errors  = 0;
        have_read    = 1'b0;
        last_word    = '0;
        void'($urandom(25));                // one seed for the whole run

        $readmemh("verif/tiled_mem_golden.txt", golden);
        n_ops = 0;
        while (n_ops < MAX_OPS && !$isunknown(golden[4*n_ops])) begin
            n_ops++;
        end
        limit       = RESET_CYCLES + 3 * n_ops + 50;  // worst case 3 cycles per op
        limit_ready = 1'b1;
        if (n_ops == 0) begin
            $display("the golden file holds no operations");
            load_errors++;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (op_idx = 0; op_idx < n_ops; op_idx++) begin
            if (golden[4*op_idx][11:8] != test_no) begin
                if (test_no != 0) begin
                    finish_test();
                end
                test_no = golden[4*op_idx][11:8];
            end
            // chained ops follow the previous one with no gap
            if (!golden[4*op_idx][4]) begin
                idle_n = $urandom % 3;
                repeat (idle_n) idle_cycle(op_idx);
            end
            run_op(op_idx);
        end
        if (test_no != 0) begin
            finish_test();
        end

        assert_fails = dut0.u_ctrl.u_props.fail_count;
        $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, assert_fails);
        if (tests_failed == 0 && assert_fails == 0 && load_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // hang guard, counts clock cycles up to the limit
    initial begin
        cycle_count = 0;
        wait (limit_ready);
        while (cycle_count < limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("Verification failed");
        $finish;
    end

endmodule

// File: verif/tiled_mem_golden.txt
// columns: op addr wdata expected, all hex
// op = test number in bits 11:8, chained (no idle gap) in bit 4, kind in bits 1:0
// kind 0 idle, 1 write, 2 read, 3 write and read together (expected is the old word)
// test 1: after reset, idle cycles and writes never raise rd_valid
100 000 00000000 00000000
100 000 00000000 00000000
101 010 0A0A0010 00000000
100 000 00000000 00000000
101 410 0B0B0410 00000000
111 810 0C0C0810 00000000
100 000 00000000 00000000
101 C10 0D0D0C10 00000000
100 000 00000000 00000000
110 000 00000000 00000000
// test 2: write then read a word in every tile
201 005 11110005 00000000
202 005 00000000 11110005
201 405 22220405 00000000
202 405 00000000 22220405
201 805 33330805 00000000
202 805 00000000 33330805
201 C05 44440C05 00000000
202 C05 00000000 44440C05
201 3FE A5A503FE 00000000
202 3FE 00000000 A5A503FE
201 7FE 5A5A07FE 00000000
202 7FE 00000000 5A5A07FE
201 BFE FFFF0BFE 00000000
202 BFE 00000000 FFFF0BFE
201 FFE 00000FFE 00000000
202 FFE 00000000 00000FFE
202 010 00000000 0A0A0010
202 410 00000000 0B0B0410
202 810 00000000 0C0C0810
202 C10 00000000 0D0D0C10
// test 3: tile boundaries and addresses that differ only in tile bits
301 3FF C0DE03FF 00000000
301 400 C0DE0400 00000000
301 7FF C0DE07FF 00000000
301 800 C0DE0800 00000000
301 BFF C0DE0BFF 00000000
301 C00 C0DE0C00 00000000
301 FFF C0DE0FFF 00000000
301 000 C0DE0000 00000000
302 3FF 00000000 C0DE03FF
302 400 00000000 C0DE0400
302 7FF 00000000 C0DE07FF
302 800 00000000 C0DE0800
302 BFF 00000000 C0DE0BFF
302 C00 00000000 C0DE0C00
302 FFF 00000000 C0DE0FFF
302 000 00000000 C0DE0000
301 123 01230000 00000000
301 523 05230001 00000000
301 923 09230002 00000000
301 D23 0D230003 00000000
302 123 00000000 01230000
302 523 00000000 05230001
302 923 00000000 09230002
302 D23 00000000 0D230003
// test 4: back to back reads hopping between tiles
402 3FF 00000000 C0DE03FF
412 400 00000000 C0DE0400
412 923 00000000 09230002
412 D23 00000000 0D230003
412 005 00000000 11110005
412 FFE 00000000 00000FFE
412 FFF 00000000 C0DE0FFF
401 2AA 2AA2AA2A 00000000
412 2AA 00000000 2AA2AA2A
412 C10 00000000 0D0D0C10
// test 5: same cycle write and read returns the old word
503 005 55550005 11110005
502 005 00000000 55550005
503 C05 5555CC05 44440C05
512 C05 00000000 5555CC05
502 123 00000000 01230000
513 123 5555A123 01230000
512 123 00000000 5555A123
503 800 66660800 C0DE0800
512 BFF 00000000 C0DE0BFF
502 800 00000000 66660800

// File: verif/tiled_mem_props.sv
`timescale 1ns/1ps

// concurrent checks on the control block, bound into access_ctrl
module tiled_mem_props import tiled_mem_pkg::*; #(
    parameter int unsigned N_TILES = 4
) (
    input logic               clk,
    input logic               reset,
    input mem_req_t           req,
    input logic [N_TILES-1:0] tile_w_en,
    input logic [N_TILES-1:0] tile_r_en,
    input logic               rd_valid
);

    int fail_count = 0;     // read back at the end of the run

    // valid exactly one cycle after each read strobe
    a_valid_after_read: assert property (@(posedge clk) disable iff (reset)
        req.r_en |=> rd_valid)
        else begin $error("rd_valid missing one cycle after a read strobe"); fail_count++; end

    a_no_valid_without_read: assert property (@(posedge clk) disable iff (reset)
        !req.r_en |=> !rd_valid)
        else begin $error("rd_valid high without a read strobe"); fail_count++; end

    // at most one tile enabled per port
    a_w_onehot: assert property (@(posedge clk) $onehot0(tile_w_en))
        else begin $error("tile_w_en has more than one bit set"); fail_count++; end

    a_r_onehot: assert property (@(posedge clk) $onehot0(tile_r_en))
        else begin $error("tile_r_en has more than one bit set"); fail_count++; end

    // reset leaves nothing in flight
    a_valid_low_after_reset: assert property (@(posedge clk) reset |=> !rd_valid)
        else begin $error("rd_valid high in the cycle after reset"); fail_count++; end

endmodule

bind access_ctrl tiled_mem_props #(.N_TILES(N_TILES)) u_props (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .tile_w_en (tile_w_en),
    .tile_r_en (tile_r_en),
    .rd_valid  (rd_valid)
);
